/* Bender.yml */
package:
  name: fetch_core

sources:
  - include_dirs:
      - src
    files:
      - src/core_pkg.sv
      - src/inst_cache.sv
      - src/fetch_unit.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/result_regfile.sv
      - src/fetch_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/fetch_core_tb.sv

/* src/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ------------------------------------------------------------
// Core and cache geometry
// ------------------------------------------------------------

`define RESET_PC 32'h3000_0000

// One cache line is one burst.
`define BLOCK_WORDS 8
`define CACHE_LINES 8

// Word offset and line index widths.
`define OFFSET_BITS ($clog2(`BLOCK_WORDS))
`define INDEX_BITS ($clog2(`CACHE_LINES))

`endif

/* src/core_pkg.sv */
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_index_t;

	// ------------------------------------------------------------
	// Decoded operations
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		op_lui,
		op_addi,
		op_jal,
		op_beq,
		op_bne,
		op_other // Retires as a no-op.
	} opcode_e;

	typedef enum logic [1:0] {
		fetch_lookup,
		fetch_request,
		fetch_refill,
		fetch_deliver
	} fetch_state_e;

endpackage

/* src/decode_stage.sv */
module decode_stage import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       inst_valid,
	input  word_t      inst_word,
	input  word_t      inst_pc,
	input  logic       redirect,
	output logic       dec_valid,
	output word_t      dec_pc,
	output opcode_e    dec_op,
	output reg_index_t dec_rd,
	output reg_index_t dec_rs1,
	output reg_index_t dec_rs2,
	output word_t      dec_imm
);

	word_t word;

	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= inst_valid && !redirect; // Wrong-path word dropped.
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			word <= inst_word;
			dec_pc <= inst_pc;
		end
	end

	assign dec_rd = word[11:7];
	assign dec_rs1 = word[19:15];
	assign dec_rs2 = word[24:20];

	always_comb begin
		dec_op = op_other;
		dec_imm = {{20{word[31]}}, word[31:20]}; // I-type.
		case (word[6:0])
			7'b0110111: begin
				dec_op = op_lui;
				dec_imm = {word[31:12], 12'b0};
			end
			7'b0010011: if (word[14:12] == 3'b000) dec_op = op_addi;
			7'b1101111: begin
				dec_op = op_jal;
				dec_imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
			end
			7'b1100011: begin
				dec_imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
				if (word[14:12] == 3'b000) dec_op = op_beq;
				if (word[14:12] == 3'b001) dec_op = op_bne;
			end
			default: ;
		endcase
	end

endmodule

/* src/execute_stage.sv */
module execute_stage import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       dec_valid,
	input  word_t      dec_pc,
	input  opcode_e    dec_op,
	input  reg_index_t dec_rd,
	input  reg_index_t dec_rs1,
	input  reg_index_t dec_rs2,
	input  word_t      dec_imm,
	output reg_index_t rs1_addr,
	output reg_index_t rs2_addr,
	input  word_t      rs1_data,
	input  word_t      rs2_data,
	output logic       redirect,
	output word_t      redirect_pc,
	output logic       wb_valid,
	output word_t      wb_pc,
	output reg_index_t wb_rd,
	output logic       wb_we,
	output word_t      wb_data
);

	word_t result;
	logic writes;
	logic taken;

	assign rs1_addr = dec_rs1;
	assign rs2_addr = dec_rs2;

	always_comb begin
		result = dec_imm;
		writes = 1'b0;
		taken = 1'b0;
		case (dec_op)
			op_lui: writes = 1'b1;
			op_addi: begin
				result = rs1_data + dec_imm;
				writes = 1'b1;
			end
			op_jal: begin
				result = dec_pc + 32'd4; // Link address.
				writes = 1'b1;
				taken = 1'b1;
			end
			op_beq: taken = (rs1_data == rs2_data);
			op_bne: taken = (rs1_data != rs2_data);
			default: ;
		endcase
	end

	// Fetch predicts fall-through, so only taken ones redirect.
	assign redirect = dec_valid && taken;
	assign redirect_pc = dec_pc + dec_imm;

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= dec_valid;
		end
	end

	always_ff @(posedge clock) begin
		wb_pc <= dec_pc;
		wb_rd <= dec_rd;
		wb_we <= writes && (dec_rd != 5'd0);
		wb_data <= result;
	end

endmodule

/* src/fetch_core.sv */
module fetch_core import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	output word_t      mem_araddr,
	output logic       mem_arvalid,
	input  logic       mem_arready,
	input  word_t      mem_rdata,
	input  logic       mem_rvalid,
	input  logic       mem_rlast,
	output logic       retire_valid,
	output word_t      retire_pc,
	output reg_index_t retire_rd,
	output logic       retire_we,
	output word_t      retire_data
);

	// ------------------------------------------------------------
	// Stage wiring
	// ------------------------------------------------------------
	word_t lookup_addr, lookup_data, fill_addr, fill_data;
	logic hit, fill_valid, fill_last;
	logic inst_valid, dec_valid, redirect, wb_valid, wb_we;
	word_t inst_word, inst_pc, dec_pc, dec_imm, redirect_pc;
	word_t rs1_data, rs2_data, wb_pc, wb_data;
	opcode_e dec_op;
	reg_index_t dec_rd, dec_rs1, dec_rs2, rs1_addr, rs2_addr, wb_rd;

	inst_cache cache_i (.*);

	fetch_unit fetch_i (.*);

	decode_stage decode_i (.*);

	execute_stage execute_i (.*);

	result_regfile result_i (.*);

endmodule

/* src/fetch_unit.sv */
`include "core_params.svh"

module fetch_unit import core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	output word_t mem_araddr,
	output logic  mem_arvalid,
	input  logic  mem_arready,
	input  word_t mem_rdata,
	input  logic  mem_rvalid,
	input  logic  mem_rlast,
	output word_t lookup_addr,
	input  logic  hit,
	input  word_t lookup_data,
	output logic  fill_valid,
	output word_t fill_addr,
	output word_t fill_data,
	output logic  fill_last,
	input  logic  redirect,
	input  word_t redirect_pc,
	output logic  inst_valid,
	output word_t inst_word,
	output word_t inst_pc
);

	fetch_state_e state;
	word_t pc;
	word_t block_addr;
	logic [`OFFSET_BITS-1:0] beat_count;
	logic squash; // Refill belongs to a dead path.
	logic beat;

	assign beat = (state == fetch_refill) && mem_rvalid;

	assign lookup_addr = pc;
	assign mem_araddr = block_addr;
	assign mem_arvalid = (state == fetch_request);

	// Beats go straight into the cache.
	assign fill_valid = beat;
	assign fill_addr = {block_addr[31:`OFFSET_BITS+2], beat_count, 2'b00};
	assign fill_data = mem_rdata;
	assign fill_last = beat && mem_rlast;

	// ------------------------------------------------------------
	// Lookup / refill FSM
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_lookup;
			pc <= `RESET_PC;
			squash <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= 1'b0;
			case (state)
				fetch_lookup: begin
					if (redirect) begin
						pc <= redirect_pc;
					end else if (hit) begin
						inst_valid <= 1'b1;
						pc <= pc + 32'd4; // Fall-through.
					end else begin
						state <= fetch_request;
					end
				end
				fetch_request: begin
					if (redirect) begin
						pc <= redirect_pc;
						squash <= 1'b1;
					end
					if (mem_arready) begin
						state <= fetch_refill;
					end
				end
				fetch_refill: begin
					if (redirect) begin
						pc <= redirect_pc;
						squash <= 1'b1;
					end
					if (fill_last) begin
						inst_valid <= !squash && !redirect;
						state <= fetch_deliver;
					end
				end
				fetch_deliver: begin
					if (redirect) begin
						pc <= redirect_pc;
					end else if (!squash) begin
						pc <= pc + 32'd4;
					end
					squash <= 1'b0;
					state <= fetch_lookup;
				end
				default: state <= fetch_lookup;
			endcase
		end
	end

	// Request address, beat count and delivered word.
	always_ff @(posedge clock) begin
		case (state)
			fetch_lookup: begin
				if (hit) begin
					inst_word <= lookup_data;
					inst_pc <= pc;
				end else begin
					block_addr <= {pc[31:`OFFSET_BITS+2], {(`OFFSET_BITS+2){1'b0}}};
				end
			end
			fetch_request: beat_count <= '0;
			fetch_refill: begin
				if (beat) begin
					beat_count <= beat_count + 1'b1;
					if (beat_count == pc[`OFFSET_BITS+1:2]) begin
						inst_word <= mem_rdata; // The word that missed.
					end
				end
				inst_pc <= pc;
			end
			default: ;
		endcase
	end

	a_araddr_stable: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

	a_no_beat_in_lookup: assert property (@(posedge clock) disable iff (reset)
		state == fetch_lookup |-> !mem_rvalid);

endmodule

/* src/inst_cache.sv */
`include "core_params.svh"

module inst_cache import core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  word_t lookup_addr,
	output logic  hit,
	output word_t lookup_data,
	input  logic  fill_valid,
	input  word_t fill_addr,
	input  word_t fill_data,
	input  logic  fill_last
);

	localparam int TAG_LSB = `OFFSET_BITS + `INDEX_BITS + 2;
	localparam int TAG_BITS = 32 - TAG_LSB;

	logic [`CACHE_LINES-1:0] valid;
	logic [TAG_BITS-1:0] tags [`CACHE_LINES];
	word_t data [`CACHE_LINES][`BLOCK_WORDS];

	logic [`INDEX_BITS-1:0] lookup_index;
	logic [`INDEX_BITS-1:0] fill_index;
	logic [`OFFSET_BITS-1:0] lookup_offset;
	logic [`OFFSET_BITS-1:0] fill_offset;

	assign lookup_index = lookup_addr[TAG_LSB-1:`OFFSET_BITS+2];
	assign lookup_offset = lookup_addr[`OFFSET_BITS+1:2];
	assign fill_index = fill_addr[TAG_LSB-1:`OFFSET_BITS+2];
	assign fill_offset = fill_addr[`OFFSET_BITS+1:2];

	assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_addr[31:TAG_LSB]);
	assign lookup_data = data[lookup_index][lookup_offset];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (fill_last) begin
			valid[fill_index] <= 1'b1; // Line complete.
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data[fill_index][fill_offset] <= fill_data;
		end
		if (fill_last) begin
			tags[fill_index] <= fill_addr[31:TAG_LSB];
		end
	end

	a_last_with_valid: assert property (@(posedge clock) disable iff (reset)
		fill_last |-> fill_valid);

endmodule

/* src/result_regfile.sv */
module result_regfile import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  reg_index_t rs1_addr,
	input  reg_index_t rs2_addr,
	output word_t      rs1_data,
	output word_t      rs2_data,
	input  logic       wb_valid,
	input  word_t      wb_pc,
	input  reg_index_t wb_rd,
	input  logic       wb_we,
	input  word_t      wb_data,
	output logic       retire_valid,
	output word_t      retire_pc,
	output reg_index_t retire_rd,
	output logic       retire_we,
	output word_t      retire_data
);

	word_t regs [1:31]; // x0 is not stored.
	logic write;

	assign write = wb_valid && wb_we;

	// Reads see the write of this cycle.
	assign rs1_data = (rs1_addr == 5'd0) ? '0 :
		(write && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 :
		(write && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

	always_ff @(posedge clock) begin
		if (write && wb_rd != 5'd0) regs[wb_rd] <= wb_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= wb_valid;
		end
	end

	always_ff @(posedge clock) begin
		retire_pc <= wb_pc;
		retire_rd <= wb_rd;
		retire_we <= wb_we;
		retire_data <= wb_data;
	end

	a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
		retire_valid && retire_we |-> retire_rd != 5'd0);

endmodule

/* testbench/fetch_core_tb.sv */
`include "core_params.svh"

module fetch_core_tb import core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	// Retires checked over all six runs, and a refill with the longest gaps.
	localparam int TOTAL_RETIRES = 124;
	localparam int REFILL_CYCLES = 48;
	localparam int WATCHDOG_NS = (TOTAL_RETIRES * 2 * REFILL_CYCLES
		+ 6 * (RESET_CYCLES + 4)) * CLOCK_PERIOD;

	logic clock;
	logic reset;
	word_t mem_araddr;
	logic mem_arvalid;
	logic mem_arready;
	word_t mem_rdata;
	logic mem_rvalid;
	logic mem_rlast;
	logic retire_valid;
	word_t retire_pc;
	reg_index_t retire_rd;
	logic retire_we;
	word_t retire_data;

	word_t mem [256]; // 1 KiB code window at RESET_PC.
	word_t model_regs [32];
	word_t model_pc;
	logic delays_on;
	int bursts; // Refills served since the last reset.
	integer seed = 32'h6541b5ca;

	fetch_core dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// ------------------------------------------------------------
	// Failure reporting and compares
	// ------------------------------------------------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t want);
		if (got !== want)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, want));
	endtask

	task automatic check_reg(input string name, input reg_index_t got, input reg_index_t want);
		if (got !== want)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, want));
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, want));
	endtask

	initial begin
		#(WATCHDOG_NS);
		report_failure($sformatf("timeout: retires did not finish within %0d ns", WATCHDOG_NS));
	end

	// ------------------------------------------------------------
	// Instruction encoding and program memory
	// ------------------------------------------------------------
	function automatic word_t lui_word(reg_index_t rd, logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic word_t addi_word(reg_index_t rd, reg_index_t rs1, logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic word_t jal_word(reg_index_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t branch_word(logic [2:0] f3, reg_index_t rs1, reg_index_t rs2,
			logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic word_t read_word(word_t addr);
		return mem[addr[9:2]];
	endfunction

	// Unused words decode as R-type, so they never write.
	task automatic fill_memory();
		word_t addr;
		for (int i = 0; i < 256; i++) begin
			addr = `RESET_PC + i * 4;
			mem[i] = {addr[31:7] ^ addr[24:0], 7'b0110011};
		end
	endtask

	task automatic place(input int offset, input word_t w);
		mem[offset >> 2] = w;
	endtask

	// ------------------------------------------------------------
	// Burst memory model
	// ------------------------------------------------------------
	task automatic random_gap();
		if (delays_on) repeat ($unsigned($random(seed)) % 4) @(negedge clock);
	endtask

	task automatic serve_burst();
		word_t base;
		random_gap();
		if (reset) return;
		base = mem_araddr;
		bursts++;
		mem_arready = 1'b1;
		@(negedge clock);
		mem_arready = 1'b0;
		for (int beat = 0; beat < `BLOCK_WORDS; beat++) begin
			random_gap();
			if (reset) return; // Burst abandoned.
			mem_rdata = read_word(base + beat * 4);
			mem_rvalid = 1'b1;
			mem_rlast = (beat == `BLOCK_WORDS - 1);
			@(negedge clock);
			mem_rvalid = 1'b0;
			mem_rlast = 1'b0;
		end
	endtask

	initial begin
		forever begin
			@(negedge clock);
			if (!reset && mem_arvalid) serve_burst();
		end
	end

	// ------------------------------------------------------------
	// ISA reference model
	// ------------------------------------------------------------
	function automatic opcode_e classify(word_t w);
		case (w[6:0])
			7'b0110111: return op_lui;
			7'b0010011: return (w[14:12] == 3'b000) ? op_addi : op_other;
			7'b1101111: return op_jal;
			7'b1100011: begin
				if (w[14:12] == 3'b000) return op_beq;
				if (w[14:12] == 3'b001) return op_bne;
				return op_other;
			end
			default: return op_other;
		endcase
	endfunction

	task automatic model_step(output word_t pc, output logic we, output reg_index_t rd,
			output word_t data);
		word_t w;
		word_t a;
		word_t b;
		word_t next_pc;
		opcode_e op;
		w = read_word(model_pc);
		op = classify(w);
		rd = w[11:7];
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		pc = model_pc;
		next_pc = model_pc + 4;
		we = 1'b1;
		data = '0;
		case (op)
			op_lui: data = {w[31:12], 12'h000};
			op_addi: data = a + {{20{w[31]}}, w[31:20]};
			op_jal: begin
				data = model_pc + 4;
				next_pc = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			op_beq, op_bne: begin
				we = 1'b0;
				if ((a == b) == (op == op_beq))
					next_pc = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			default: we = 1'b0;
		endcase
		if (rd == 5'd0) we = 1'b0;
		if (we) model_regs[rd] = data;
		model_pc = next_pc;
	endtask

	// ------------------------------------------------------------
	// Reset and run
	// ------------------------------------------------------------
	task automatic apply_reset();
		@(negedge clock);
		reset = 1'b1;
		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_flag("mem_arvalid", mem_arvalid, 1'b0);
			check_flag("retire_valid", retire_valid, 1'b0);
		end
		reset = 1'b0;
		@(negedge clock);
		check_flag("retire_valid", retire_valid, 1'b0);
		while (!mem_arvalid) @(negedge clock);
		check_word("mem_araddr", mem_araddr, `RESET_PC);
	endtask

	task automatic run_program(input int count, input logic random_delays);
		word_t pc;
		word_t data;
		logic we;
		reg_index_t rd;
		delays_on = random_delays;
		model_pc = `RESET_PC;
		foreach (model_regs[i]) model_regs[i] = '0;
		bursts = 0;
		apply_reset();
		for (int i = 0; i < count; i++) begin
			do @(negedge clock); while (!retire_valid);
			model_step(pc, we, rd, data);
			check_word("retire_pc", retire_pc, pc);
			check_flag("retire_we", retire_we, we);
			if (we) begin
				check_reg("retire_rd", retire_rd, rd);
				check_word("retire_data", retire_data, data);
			end
		end
	endtask

	task automatic straight_line_test();
		fill_memory();
		place(32'h00, lui_word(1, 20'h12345));
		place(32'h04, addi_word(2, 1, 12'h678));
		place(32'h08, 32'h0020_81b3); // add, not supported.
		place(32'h0c, addi_word(0, 2, 12'h005));
		place(32'h10, addi_word(4, 2, 12'hfff));
		place(32'h14, jal_word(0, 0));
		run_program(8, 1'b0);
	endtask

	task automatic loop_test(input logic random_delays);
		fill_memory();
		place(32'h00, addi_word(1, 0, 12'd10));
		place(32'h04, addi_word(2, 0, 12'd0));
		place(32'h08, addi_word(2, 2, 12'd3));
		place(32'h0c, addi_word(1, 1, 12'hfff));
		place(32'h10, branch_word(3'b001, 1, 0, -8));
		place(32'h14, lui_word(5, 20'habcde));
		place(32'h18, jal_word(0, 0));
		run_program(36, random_delays);
		// Whole program fits in one line, so only the first miss refills.
		if (bursts != 1)
			report_failure($sformatf("loop body missed in the cache, %0d refills seen", bursts));
	endtask

	task automatic jal_test();
		fill_memory();
		place(32'h00, addi_word(1, 0, 12'd7));
		place(32'h04, jal_word(3, 21'h40));
		place(32'h08, addi_word(1, 0, 12'd99)); // Skipped.
		place(32'h44, addi_word(4, 3, 12'd1));
		place(32'h48, jal_word(0, 0));
		run_program(6, 1'b0);
	endtask

	// Blocks at +0x000 and +0x100 share cache index 0.
	task automatic conflict_test(input logic random_delays);
		fill_memory();
		place(32'h000, addi_word(1, 0, 12'd3));
		place(32'h004, addi_word(2, 0, 12'd0));
		place(32'h008, jal_word(5, 21'h0f8));
		place(32'h00c, addi_word(1, 1, 12'hfff));
		place(32'h010, branch_word(3'b001, 1, 0, -8));
		place(32'h014, jal_word(0, 0));
		place(32'h100, addi_word(2, 2, 12'd5));
		place(32'h104, jal_word(0, -21'h0f8));
		run_program(19, random_delays);
	endtask

	initial begin
		reset = 1'b1;
		mem_arready = 1'b0;
		mem_rdata = '0;
		mem_rvalid = 1'b0;
		mem_rlast = 1'b0;
		delays_on = 1'b0;
		straight_line_test();
		loop_test(1'b0);
		jal_test();
		conflict_test(1'b0);
		loop_test(1'b1);
		conflict_test(1'b1);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+src
src/core_pkg.sv
src/inst_cache.sv
src/fetch_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_regfile.sv
src/fetch_core.sv
testbench/fetch_core_tb.sv
